/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lsu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Test passed" || (echo "Test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
source/lsu_pkg.sv
source/lsu_pipe.sv
source/lsu_stbuf.sv
source/lsu_drain_fsm.sv
source/lsu_starve_timer.sv
source/lsu_dccm.sv
source/lsu_load_align.sv
source/lsu_top.sv
verif/lsu_props.sv
verif/lsu_tb.sv

/* source/lsu_dccm.sv */
/*
 * DCCM
 * Single-port data memory with byte write enables. The read address is
 * sampled at the clock edge and data appears in the following cycle.
 */
`timescale 1ns/1ns

module lsu_dccm (
   input  logic                           clk,
   input  logic [lsu_pkg::DCCM_IDX_W-1:0] rd_idx,
   input  logic                           wr_en,
   input  logic [lsu_pkg::DCCM_IDX_W-1:0] wr_idx,
   input  logic [31:0]                    wr_data,
   input  logic [3:0]                     wr_be,
   output logic [31:0]                    rd_data
);

   logic [31:0] mem [lsu_pkg::DCCM_WORDS];

   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (wr_en && wr_be[b]) begin
            mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
      rd_data <= mem[rd_idx];                                         // Registered read
   end

endmodule

/* source/lsu_drain_fsm.sv */
/*
 * Store buffer drain control
 * Lets the oldest entry write the DCCM in cycles where DC1 has no load.
 * After a long run of blocked drains it stalls loads until one entry drains.
 */
`timescale 1ns/1ns

module lsu_drain_fsm (
   input  logic              clk,
   input  logic              arst_n,
   input  lsu_pkg::lsu_pkt_t pkt_dc1,
   input  logic              stbuf_empty,
   input  logic              starve_expired,
   output logic              drain_en,
   output logic              drain_blocked,
   output logic              lsu_load_stall
);

   lsu_pkg::lsu_drain_e state;
   lsu_pkg::lsu_drain_e state_nxt;
   logic                dc1_load;
   logic                pending;

   assign dc1_load = pkt_dc1.valid & pkt_dc1.load;                    // Owns the DCCM port
   assign pending  = (state != lsu_pkg::IDLE) & ~stbuf_empty;

   assign drain_en       = pending & ~dc1_load;
   assign drain_blocked  = pending & dc1_load;
   assign lsu_load_stall = (state == lsu_pkg::PRIORITY);

   always_comb begin
      state_nxt = state;
      case (state)
         lsu_pkg::IDLE: begin
            if (!stbuf_empty) begin
               state_nxt = lsu_pkg::DRAIN;
            end
         end
         lsu_pkg::DRAIN: begin
            if (stbuf_empty) begin
               state_nxt = lsu_pkg::IDLE;
            end else if (starve_expired) begin
               state_nxt = lsu_pkg::PRIORITY;
            end
         end
         lsu_pkg::PRIORITY: begin
            if (stbuf_empty) begin
               state_nxt = lsu_pkg::IDLE;
            end else if (drain_en) begin
               state_nxt = lsu_pkg::DRAIN;                             // One entry is enough
            end
         end
         default: state_nxt = lsu_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= lsu_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

/* source/lsu_load_align.sv */
/*
 * DC3 load data alignment
 * Merges forwarded store bytes over DCCM data, shifts the addressed bytes
 * down and extends them to 32 bits by size and sign.
 */
`timescale 1ns/1ns

module lsu_load_align (
   input  lsu_pkg::lsu_pkt_t    pkt_dc3,
   input  logic                 flush_dc3,
   input  logic [31:0]          rd_data_dc3,
   input  lsu_pkg::lsu_fwd_t    fwd_dc3,
   output lsu_pkg::lsu_result_t lsu_result
);

   logic [31:0] merged;
   logic [31:0] shifted;
   logic        sext;

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = fwd_dc3.be[b] ? fwd_dc3.data[8*b +: 8] : rd_data_dc3[8*b +: 8];
      end
   end

   assign shifted = merged >> {pkt_dc3.addr.f.byte_off, 3'b000};
   assign sext    = ~pkt_dc3.unsign;

   always_comb begin
      lsu_result.valid = pkt_dc3.valid & pkt_dc3.load & ~flush_dc3;  // Faulted loads have no load bit
      case (pkt_dc3.size)
         lsu_pkg::SZ_BYTE: lsu_result.data = {{24{sext & shifted[7]}}, shifted[7:0]};
         lsu_pkg::SZ_HALF: lsu_result.data = {{16{sext & shifted[15]}}, shifted[15:0]};
         default:          lsu_result.data = shifted;
      endcase
   end

endmodule

/* source/lsu_pipe.sv */
/*
 * LSU pipeline
 * DC1 to DC3 stage registers. Forms the address from base and offset,
 * puts store data on its byte lanes and checks alignment and region in
 * DC1. The error packet is reported in DC3 and dropped on a flush.
 */
`timescale 1ns/1ns

module lsu_pipe (
   input  logic                clk,
   input  logic                arst_n,
   input  lsu_pkg::lsu_req_t   lsu_req,
   input  logic                flush_dc3,
   input  logic                stbuf_empty,
   output lsu_pkg::lsu_pkt_t   pkt_dc1,
   output lsu_pkg::lsu_pkt_t   pkt_dc2,
   output lsu_pkg::lsu_pkt_t   pkt_dc3,
   output logic [1:0]          stores_in_flight,
   output lsu_pkg::lsu_error_t lsu_error_dc3,
   output logic                lsu_idle
);

   lsu_pkg::lsu_req_t   req_dc1;
   lsu_pkg::lsu_addr_u  addr_dc1;
   lsu_pkg::lsu_error_t err_dc1;
   lsu_pkg::lsu_error_t err_dc2;
   lsu_pkg::lsu_error_t err_dc3;
   logic [3:0]          be_dc1;
   logic                op_dc1;
   logic                misaligned_dc1;
   logic                fault_dc1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_dc1 <= '0;
      end else begin
         req_dc1 <= lsu_req;
      end
   end

   //**************************************************
   // DC1 address generation and checks
   //**************************************************
   assign addr_dc1.byte_addr = req_dc1.rs1 + {{20{req_dc1.offset[11]}}, req_dc1.offset};

   assign op_dc1         = req_dc1.valid & (req_dc1.load | req_dc1.store);
   assign misaligned_dc1 = ((req_dc1.size == lsu_pkg::SZ_HALF) & addr_dc1.f.byte_off[0]) |
                           ((req_dc1.size == lsu_pkg::SZ_WORD) & (|addr_dc1.f.byte_off));
   assign fault_dc1      = (addr_dc1.f.region != lsu_pkg::DCCM_REGION) | (|addr_dc1.f.unused);

   always_comb begin
      err_dc1.misaligned   = op_dc1 & misaligned_dc1;
      err_dc1.access_fault = op_dc1 & fault_dc1;
      err_dc1.exc_valid    = err_dc1.misaligned | err_dc1.access_fault;
      err_dc1.addr         = addr_dc1.byte_addr;
   end

   always_comb begin
      case (req_dc1.size)
         lsu_pkg::SZ_BYTE: be_dc1 = 4'b0001;
         lsu_pkg::SZ_HALF: be_dc1 = 4'b0011;
         default:          be_dc1 = 4'b1111;
      endcase
   end

   always_comb begin
      pkt_dc1.valid  = req_dc1.valid;
      pkt_dc1.load   = req_dc1.valid & req_dc1.load & ~err_dc1.exc_valid;  // Faulted ops do nothing
      pkt_dc1.store  = req_dc1.valid & req_dc1.store & ~err_dc1.exc_valid;
      pkt_dc1.unsign = req_dc1.unsign;
      pkt_dc1.size   = req_dc1.size;
      pkt_dc1.addr   = addr_dc1;
      pkt_dc1.wdata  = req_dc1.store_data << {addr_dc1.f.byte_off, 3'b000};
      pkt_dc1.be     = be_dc1 << addr_dc1.f.byte_off;
   end

   //**************************************************
   // DC2 and DC3 stage registers
   //**************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_dc2 <= '0;
         pkt_dc3 <= '0;
         err_dc2 <= '0;
         err_dc3 <= '0;
      end else begin
         pkt_dc2 <= pkt_dc1;
         pkt_dc3 <= pkt_dc2;
         err_dc2 <= err_dc1;
         err_dc3 <= err_dc2;
      end
   end

   always_comb begin
      lsu_error_dc3           = err_dc3;
      lsu_error_dc3.exc_valid = err_dc3.exc_valid & ~flush_dc3;  // Killed access reports nothing
   end

   assign stores_in_flight = {1'b0, pkt_dc1.store} + {1'b0, pkt_dc2.store} +
                             {1'b0, pkt_dc3.store};

   assign lsu_idle = ~(pkt_dc1.valid | pkt_dc2.valid | pkt_dc3.valid) & stbuf_empty;

endmodule

/* source/lsu_pkg.sv */
/*
 * LSU package
 * Sizes of the DCCM, the store buffer and the starvation timer, and the
 * packets that move between the stages of the load/store pipeline.
 */
package lsu_pkg;

   localparam int         DCCM_WORDS   = 256;                      // 32-bit words
   localparam int         DCCM_IDX_W   = 8;                        // Word index width
   localparam logic [3:0] DCCM_REGION  = 4'hf;                     // Address bits 31:28
   localparam int         STBUF_DEPTH  = 4;
   localparam int         STBUF_PTR_W  = 2;
   localparam int         STARVE_LIMIT = 8;                        // Blocked drains before load stall
   localparam int         STARVE_CNT_W = $clog2(STARVE_LIMIT + 1);

   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   typedef struct packed {
      logic        valid;
      logic        load;
      logic        store;
      logic        unsign;                                         // Zero extend on load
      lsu_size_e   size;
      logic [31:0] rs1;                                            // Base register
      logic [11:0] offset;                                         // Signed immediate
      logic [31:0] store_data;
   } lsu_req_t;

   // One address, seen either as a byte address or as DCCM fields
   typedef union packed {
      logic [31:0] byte_addr;
      struct packed {
         logic [3:0]            region;
         logic [17:0]           unused;                            // Must be zero inside the DCCM
         logic [DCCM_IDX_W-1:0] index;
         logic [1:0]            byte_off;
      } f;
   } lsu_addr_u;

   typedef struct packed {
      logic        valid;
      logic        load;                                           // Cleared on a fault
      logic        store;                                          // Cleared on a fault
      logic        unsign;
      lsu_size_e   size;
      lsu_addr_u   addr;
      logic [31:0] wdata;                                          // Already on its byte lanes
      logic [3:0]  be;
   } lsu_pkt_t;

   typedef struct packed {
      logic        exc_valid;
      logic        misaligned;
      logic        access_fault;
      logic [31:0] addr;
   } lsu_error_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
   } lsu_result_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  be;
   } lsu_fwd_t;

   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      DRAIN    = 2'd1,
      PRIORITY = 2'd2
   } lsu_drain_e;

endpackage

/* source/lsu_starve_timer.sv */
/*
 * Drain starvation timer
 * Counts consecutive cycles in which loads block a pending drain.
 */
`timescale 1ns/1ns

module lsu_starve_timer (
   input  logic clk,
   input  logic arst_n,
   input  logic drain_blocked,
   output logic starve_expired
);

   logic [lsu_pkg::STARVE_CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= '0;
      end else if (!drain_blocked) begin
         cnt <= '0;                                                   // Any free cycle restarts
      end else if (!starve_expired) begin
         cnt <= cnt + 1'b1;                                           // Saturates at the limit
      end
   end

   assign starve_expired = (cnt == (lsu_pkg::STARVE_CNT_W)'(lsu_pkg::STARVE_LIMIT));

endmodule

/* source/lsu_stbuf.sv */
/*
 * Store buffer
 * Holds committed stores until the drain control writes them into the
 * DCCM, oldest first. Compares the DC2 load against its entries and the
 * DC3 store byte by byte and registers the forwarded bytes for DC3.
 */
`timescale 1ns/1ns

module lsu_stbuf (
   input  logic                               clk,
   input  logic                               arst_n,
   input  lsu_pkg::lsu_pkt_t                  pkt_dc2,
   input  lsu_pkg::lsu_pkt_t                  pkt_dc3,
   input  logic                               flush_dc3,
   input  logic                               drain_en,
   input  logic [1:0]                         stores_in_flight,
   output logic                               dccm_wr_en,
   output logic [lsu_pkg::DCCM_IDX_W-1:0]     dccm_wr_idx,
   output logic [31:0]                        dccm_wr_data,
   output logic [3:0]                         dccm_wr_be,
   output lsu_pkg::lsu_fwd_t                  fwd_dc3,
   output logic                               stbuf_empty,
   output logic                               lsu_store_stall
);

   typedef struct packed {
      logic [lsu_pkg::DCCM_IDX_W-1:0] idx;
      logic [31:0]                    data;
      logic [3:0]                     be;
   } stbuf_entry_t;

   stbuf_entry_t                    entry [lsu_pkg::STBUF_DEPTH];
   logic [lsu_pkg::STBUF_DEPTH-1:0] vld;
   logic [lsu_pkg::STBUF_PTR_W-1:0] wr_ptr;
   logic [lsu_pkg::STBUF_PTR_W-1:0] rd_ptr;
   logic [lsu_pkg::STBUF_PTR_W:0]   count;
   logic [lsu_pkg::STBUF_PTR_W:0]   free;
   logic                            wr_en;
   lsu_pkg::lsu_fwd_t               fwd_dc2;

   assign wr_en = pkt_dc3.valid & pkt_dc3.store & ~flush_dc3;  // Commit from DC3

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld    <= '0;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            vld[wr_ptr] <= 1'b1;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (drain_en) begin
            vld[rd_ptr] <= 1'b0;                               // Pop oldest
            rd_ptr      <= rd_ptr + 1'b1;
         end
         count <= count + {{lsu_pkg::STBUF_PTR_W{1'b0}}, wr_en} -
                  {{lsu_pkg::STBUF_PTR_W{1'b0}}, drain_en};
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         entry[wr_ptr] <= '{idx: pkt_dc3.addr.f.index, data: pkt_dc3.wdata, be: pkt_dc3.be};
      end
   end

   assign dccm_wr_en   = drain_en;
   assign dccm_wr_idx  = entry[rd_ptr].idx;
   assign dccm_wr_data = entry[rd_ptr].data;
   assign dccm_wr_be   = entry[rd_ptr].be;

   //**************************************************
   // Store-to-load forwarding, compared in DC2
   //**************************************************
   always_comb begin
      logic [lsu_pkg::STBUF_PTR_W-1:0] ptr;
      fwd_dc2 = '0;
      // Walk oldest to newest so younger bytes overwrite older ones
      for (int i = 0; i < lsu_pkg::STBUF_DEPTH; i++) begin
         ptr = rd_ptr + i[lsu_pkg::STBUF_PTR_W-1:0];
         for (int b = 0; b < 4; b++) begin
            if (vld[ptr] && entry[ptr].be[b] && (entry[ptr].idx == pkt_dc2.addr.f.index)) begin
               fwd_dc2.data[8*b +: 8] = entry[ptr].data[8*b +: 8];
               fwd_dc2.be[b]          = 1'b1;
            end
         end
      end
      for (int b = 0; b < 4; b++) begin
         if (wr_en && pkt_dc3.be[b] && (pkt_dc3.addr.f.index == pkt_dc2.addr.f.index)) begin
            fwd_dc2.data[8*b +: 8] = pkt_dc3.wdata[8*b +: 8];  // DC3 store is youngest
            fwd_dc2.be[b]          = 1'b1;
         end
      end
      if (!(pkt_dc2.valid && pkt_dc2.load)) begin
         fwd_dc2.be = '0;
      end
   end

   always_ff @(posedge clk) begin
      fwd_dc3 <= fwd_dc2;
   end

   assign free            = (lsu_pkg::STBUF_PTR_W + 1)'(lsu_pkg::STBUF_DEPTH) - count;
   assign stbuf_empty     = (count == '0);
   assign lsu_store_stall = (free <= {1'b0, stores_in_flight});  // Room for every store in flight

endmodule

/* source/lsu_top.sv */
/*
 * Load/store unit
 * Three-stage pipeline serving loads and stores to a local DCCM through a
 * store buffer with forwarding and starvation-aware drain control.
 */
`timescale 1ns/1ns

module lsu_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  lsu_pkg::lsu_req_t    lsu_req,
   input  logic                 flush_dc3,
   output lsu_pkg::lsu_result_t lsu_result,
   output lsu_pkg::lsu_error_t  lsu_error_dc3,
   output logic                 lsu_load_stall,
   output logic                 lsu_store_stall,
   output logic                 lsu_idle
);

   lsu_pkg::lsu_pkt_t              pkt_dc1;
   lsu_pkg::lsu_pkt_t              pkt_dc2;
   lsu_pkg::lsu_pkt_t              pkt_dc3;
   lsu_pkg::lsu_fwd_t              fwd_dc3;
   logic [1:0]                     stores_in_flight;
   logic                           stbuf_empty;
   logic                           drain_en;
   logic                           drain_blocked;
   logic                           starve_expired;
   logic                           dccm_wr_en;
   logic [lsu_pkg::DCCM_IDX_W-1:0] dccm_wr_idx;
   logic [31:0]                    dccm_wr_data;
   logic [3:0]                     dccm_wr_be;
   logic [31:0]                    rd_data_dc2;
   logic [31:0]                    rd_data_dc3;

   lsu_pipe u_pipe (
      .clk, .arst_n, .lsu_req, .flush_dc3, .stbuf_empty,
      .pkt_dc1, .pkt_dc2, .pkt_dc3, .stores_in_flight, .lsu_error_dc3, .lsu_idle
   );

   lsu_stbuf u_stbuf (
      .clk, .arst_n, .pkt_dc2, .pkt_dc3, .flush_dc3, .drain_en, .stores_in_flight,
      .dccm_wr_en, .dccm_wr_idx, .dccm_wr_data, .dccm_wr_be,
      .fwd_dc3, .stbuf_empty, .lsu_store_stall
   );

   lsu_drain_fsm u_drain_fsm (
      .clk, .arst_n, .pkt_dc1, .stbuf_empty, .starve_expired,
      .drain_en, .drain_blocked, .lsu_load_stall
   );

   lsu_starve_timer u_starve_timer (.clk, .arst_n, .drain_blocked, .starve_expired);

   lsu_dccm u_dccm (
      .clk,
      .rd_idx  (pkt_dc1.addr.f.index),                                // Load reads in DC1
      .wr_en   (dccm_wr_en),
      .wr_idx  (dccm_wr_idx),
      .wr_data (dccm_wr_data),
      .wr_be   (dccm_wr_be),
      .rd_data (rd_data_dc2)
   );

   // DC2 read data follows its load into DC3
   always_ff @(posedge clk) begin
      rd_data_dc3 <= rd_data_dc2;
   end

   lsu_load_align u_load_align (.pkt_dc3, .flush_dc3, .rd_data_dc3, .fwd_dc3, .lsu_result);

endmodule

/* verif/lsu_props.sv */
/*
 * LSU properties
 * Concurrent checks on store buffer occupancy, DCCM port sharing, release
 * of the load stall and the state of the outputs during reset.
 */
`timescale 1ns/1ns

module lsu_props (
   input logic                          clk,
   input logic                          arst_n,
   input logic [lsu_pkg::STBUF_PTR_W:0] stbuf_count,
   input logic                          drain_en,
   input lsu_pkg::lsu_pkt_t             pkt_dc1,
   input lsu_pkg::lsu_result_t          lsu_result,
   input lsu_pkg::lsu_error_t           lsu_error_dc3,
   input logic                          lsu_load_stall,
   input logic                          lsu_store_stall,
   input logic                          lsu_idle
);

   count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_count <= lsu_pkg::STBUF_DEPTH)
      else $error("Store buffer holds more entries than its depth");

   // DC1 load owns the single DCCM port
   drain_vs_load: assert property (@(posedge clk) disable iff (!arst_n)
      !(drain_en && pkt_dc1.valid && pkt_dc1.load))
      else $error("Drain write collides with a DC1 load read");

   stall_release: assert property (@(posedge clk) disable iff (!arst_n)
      $past(lsu_load_stall, 2) |-> (drain_en || $past(drain_en) || $past(drain_en, 2)))
      else $error("Load stall not followed by a drain within 2 cycles");

   reset_outputs: assert property (@(posedge clk)
      (!arst_n && !$past(arst_n)) |-> (!lsu_result.valid && !lsu_error_dc3.exc_valid &&
                                       !lsu_load_stall && !lsu_store_stall && lsu_idle))
      else $error("Outputs active during reset");

endmodule

bind lsu_top lsu_props u_props (
   .clk,
   .arst_n,
   .stbuf_count (u_stbuf.count),
   .drain_en,
   .pkt_dc1,
   .lsu_result,
   .lsu_error_dc3,
   .lsu_load_stall,
   .lsu_store_stall,
   .lsu_idle
);

/* verif/lsu_tb.sv */
/*
 * LSU testbench
 * Drives loads and stores into the load/store unit from an LFSR, keeps a
 * byte-wide reference memory updated in commit order and checks every DC3
 * result and error packet against it with immediate assertions.
 */
`timescale 1ns/1ns

module lsu_tb;

   localparam logic [31:0] LFSR_TAPS = 32'h80200003;
   localparam logic [31:0] WIN_BASE  = 32'hf000_0140;             // 16-word test window

   logic                 clk;
   logic                 arst_n;
   lsu_pkg::lsu_req_t    lsu_req;
   logic                 flush_dc3;
   lsu_pkg::lsu_result_t lsu_result;
   lsu_pkg::lsu_error_t  lsu_error_dc3;
   logic                 lsu_load_stall;
   logic                 lsu_store_stall;
   logic                 lsu_idle;

   logic [31:0]          lfsr;
   logic [7:0]           ref_mem [1024];
   lsu_pkg::lsu_req_t    inflight [$];                              // Requests in DC1 to DC3
   logic                 seen_load_stall;
   logic                 seen_store_stall;

   lsu_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] win_addr(input logic [3:0] idx, input logic [1:0] off);
      return WIN_BASE + {26'b0, idx, off};
   endfunction

   // Base and offset are chosen so that their sum is the wanted address
   function automatic lsu_pkg::lsu_req_t make_req(input logic load, input lsu_pkg::lsu_size_e size,
                                                  input logic [31:0] addr, input logic [31:0] data);
      lsu_pkg::lsu_req_t r;
      r.valid      = 1'b1;
      r.load       = load;
      r.store      = ~load;
      r.unsign     = take_bits(1) != 0;
      r.size       = size;
      r.offset     = 12'(take_bits(12));
      r.rs1        = addr - {{20{r.offset[11]}}, r.offset};
      r.store_data = data;
      return r;
   endfunction

   function automatic lsu_pkg::lsu_req_t random_req();
      logic [3:0]  kind;
      logic [1:0]  sz;
      logic [31:0] addr;
      kind = 4'(take_bits(4));
      sz   = 2'(take_bits(2));
      addr = WIN_BASE + take_bits(6);
      if (sz == 2'd3) begin
         sz = 2'd2;
      end
      if (kind[2]) begin
         addr[1:0] = 2'b00;                                         // Mostly aligned traffic
      end
      if (kind == 4'd0) begin
         addr[31:28] = 4'h3;                                        // Outside the DCCM region
      end else if (kind == 4'd1) begin
         addr[19] = 1'b1;                                           // Unused field not zero
      end
      return make_req(kind[3], lsu_pkg::lsu_size_e'(sz), addr, take_bits(32));
   endfunction

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   //**************************************************
   // Expected DC3 response and reference memory commit
   //**************************************************
   task automatic check_dc3(input lsu_pkg::lsu_req_t r, input logic flush);
      logic [31:0] addr;
      logic [31:0] word;
      logic [31:0] exp_data;
      logic        mis;
      logic        fault;
      logic        exc;
      logic        live;
      addr  = r.rs1 + {{20{r.offset[11]}}, r.offset};
      mis   = ((r.size == lsu_pkg::SZ_HALF) && addr[0]) ||
              ((r.size == lsu_pkg::SZ_WORD) && (addr[1:0] != 2'b00));
      fault = (addr[31:28] != lsu_pkg::DCCM_REGION) || (addr[27:10] != '0);
      exc   = r.valid && (mis || fault);
      live  = r.valid && !exc && !flush;
      for (int b = 0; b < 4; b++) begin
         word[8*b +: 8] = ref_mem[addr[9:0] + 10'(b)];
      end
      case (r.size)
         lsu_pkg::SZ_BYTE: exp_data = {{24{~r.unsign & word[7]}}, word[7:0]};
         lsu_pkg::SZ_HALF: exp_data = {{16{~r.unsign & word[15]}}, word[15:0]};
         default:          exp_data = word;
      endcase
      check_value("lsu_error_dc3.exc_valid", 32'(exc && !flush), 32'(lsu_error_dc3.exc_valid));
      if (exc && !flush) begin
         check_value("lsu_error_dc3.misaligned", 32'(mis), 32'(lsu_error_dc3.misaligned));
         check_value("lsu_error_dc3.access_fault", 32'(fault), 32'(lsu_error_dc3.access_fault));
         check_value("lsu_error_dc3.addr", addr, lsu_error_dc3.addr);
      end
      check_value("lsu_result.valid", 32'(live && r.load), 32'(lsu_result.valid));
      if (live && r.load) begin
         check_value("lsu_result.data", exp_data, lsu_result.data);
      end
      if (live && r.store) begin
         for (int b = 0; b < (1 << int'(r.size)); b++) begin
            ref_mem[addr[9:0] + 10'(b)] = r.store_data[8*b +: 8];
         end
      end
   endtask

   // One clock per pass; a stalled request is held back and retried
   task automatic run_cycle(input lsu_pkg::lsu_req_t req, input logic flush);
      lsu_pkg::lsu_req_t dc3_req;
      logic              blocked;
      int                tries;
      tries   = 0;
      blocked = 1'b1;
      while (blocked) begin
         @(posedge clk);
         #10;
         blocked          = (req.load && lsu_load_stall) || (req.store && lsu_store_stall);
         seen_load_stall  = seen_load_stall | lsu_load_stall;
         seen_store_stall = seen_store_stall | lsu_store_stall;
         dc3_req          = inflight.pop_front();
         if (blocked) begin
            lsu_req = '0;
         end else begin
            lsu_req = req;
         end
         flush_dc3 = flush && (tries == 0);                         // Only the first DC3 op
         inflight.push_back(lsu_req);
         @(negedge clk);
         check_dc3(dc3_req, flush_dc3);
         tries++;
         if (blocked && tries > 20) begin
            $display("Timeout: request held back by a stall for more than 20 cycles");
            abort_run();
         end
      end
   endtask

   //**************************************************
   // Test sequence
   //**************************************************
   initial begin
      lsu_pkg::lsu_req_t req;
      logic              flush;
      int                idle_wait;
      lfsr             = 32'h4ebfc337;
      lsu_req          = '0;
      flush_dc3        = 1'b0;
      arst_n           = 1'b0;
      seen_load_stall  = 1'b0;
      seen_store_stall = 1'b0;
      for (int i = 0; i < 3; i++) begin
         inflight.push_back('0);
      end
      repeat (2) @(posedge clk);
      #10;
      arst_n = 1'b1;
      check_value("lsu_idle", 32'd1, 32'(lsu_idle));

      for (int w = 0; w < 16; w++) begin                            // Known bytes in the window
         run_cycle(make_req(1'b0, lsu_pkg::SZ_WORD, win_addr(4'(w), 2'd0),
                            win_addr(4'(w), 2'd0) * 32'h9e3779b9), 1'b0);
      end

      // Forwarding from the DC3 store, then from a buffer entry
      run_cycle(make_req(1'b0, lsu_pkg::SZ_BYTE, win_addr(4'd3, 2'd1), take_bits(32)), 1'b0);
      run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'd3, 2'd0), '0), 1'b0);
      run_cycle(make_req(1'b0, lsu_pkg::SZ_HALF, win_addr(4'd4, 2'd2), take_bits(32)), 1'b0);
      run_cycle('0, 1'b0);
      run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'd4, 2'd0), '0), 1'b0);

      // Misaligned and out-of-region accesses, then a store killed in DC3
      run_cycle(make_req(1'b0, lsu_pkg::SZ_HALF, win_addr(4'd5, 2'd1), take_bits(32)), 1'b0);
      run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'd5, 2'd2), '0), 1'b0);
      run_cycle(make_req(1'b0, lsu_pkg::SZ_WORD, 32'h7000_0140, take_bits(32)), 1'b0);
      run_cycle(make_req(1'b0, lsu_pkg::SZ_WORD, 32'hf000_4140, take_bits(32)), 1'b0);
      run_cycle(make_req(1'b0, lsu_pkg::SZ_WORD, win_addr(4'd6, 2'd0), take_bits(32)), 1'b0);
      run_cycle('0, 1'b0);
      run_cycle('0, 1'b0);
      run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'd6, 2'd0), '0), 1'b1);

      for (int i = 0; i < 400; i++) begin
         req   = random_req();
         flush = (take_bits(3) == 0);
         run_cycle(req, flush);
      end

      // Back-to-back stores, then a load stream that starves the drain
      for (int i = 0; i < 8; i++) begin
         run_cycle(make_req(1'b0, lsu_pkg::SZ_WORD, win_addr(4'(take_bits(4)), 2'd0),
                            take_bits(32)), 1'b0);
      end
      for (int i = 0; i < 30; i++) begin
         run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'(take_bits(4)), 2'd0), '0), 1'b0);
      end
      for (int w = 0; w < 16; w++) begin
         run_cycle(make_req(1'b1, lsu_pkg::SZ_WORD, win_addr(4'(w), 2'd0), '0), 1'b0);
      end
      repeat (3) run_cycle('0, 1'b0);

      idle_wait = 0;
      while (!lsu_idle) begin
         run_cycle('0, 1'b0);
         idle_wait++;
         if (idle_wait > 20) begin
            $display("Timeout: lsu_idle did not return high after the store buffer drained");
            abort_run();
         end
      end
      assert (seen_load_stall && seen_store_stall) else begin
         $display("Load stall or store stall never rose during the run");
         abort_run();
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
